// ==== Bender.yml ====
package:
  name: mod_reduce

sources:
  - files:
      - design/operand_pkg.sv
      - design/rns_pkg.sv
      - design/residue_reducer.sv
      - design/crt_combiner.sv
      - design/mod_reduce_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_mod_reduce.sv

// ==== design/crt_combiner.sv ====
`timescale 1ns/10ps

module crt_combiner (
  input  logic              clk,
  input  logic              rst,
  input  rns_pkg::residue_t residue_a,
  input  rns_pkg::residue_t residue_b,
  input  logic              residue_valid,
  output rns_pkg::result_t  result,
  output logic              result_valid
);

  rns_pkg::residue_wide_t diff_raw;
  rns_pkg::residue_t      diff;
  rns_pkg::crt_prod_t     prod_q;
  rns_pkg::residue_t      res_a_q;
  rns_pkg::residue_wide_t prod_fold;
  rns_pkg::residue_t      t;
  logic                   vld_s1;

  // (b - a) mod mod_b.
  always_comb
  begin
    diff_raw = {1'b0, residue_b} - {1'b0, residue_a};
    if (diff_raw[rns_pkg::residue_width])   // Borrow out.
      diff = rns_pkg::residue_t'(diff_raw + rns_pkg::mod_b);
    else
      diff = rns_pkg::residue_t'(diff_raw);
  end

  always_ff @(posedge clk)
  begin
    prod_q  <= rns_pkg::crt_prod_t'(diff) * rns_pkg::crt_prod_t'(rns_pkg::inv_a_mod_b);
    res_a_q <= residue_a;
  end

  // Product mod mod_b, fold first then up to two subtracts.
  always_comb
  begin
    prod_fold = rns_pkg::residue_wide_t'(
                  (prod_q >> rns_pkg::fold_bits) * rns_pkg::fold_weight(rns_pkg::mod_b)
                  + prod_q[rns_pkg::fold_bits-1:0]);
    if (prod_fold >= 2 * rns_pkg::mod_b)
      t = rns_pkg::residue_t'(prod_fold - 2 * rns_pkg::mod_b);
    else if (prod_fold >= rns_pkg::mod_b)
      t = rns_pkg::residue_t'(prod_fold - rns_pkg::mod_b);
    else
      t = rns_pkg::residue_t'(prod_fold);
  end

  always_ff @(posedge clk)
  begin
    result <= rns_pkg::result_t'(res_a_q)
            + rns_pkg::result_t'(rns_pkg::mod_a) * rns_pkg::result_t'(t);   // a + 997 * t.
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      vld_s1       <= 1'b0;
      result_valid <= 1'b0;
    end
    else
    begin
      vld_s1       <= residue_valid;
      result_valid <= vld_s1;
    end
  end

endmodule

// ==== design/mod_reduce_top.sv ====
`timescale 1ns/10ps

module mod_reduce_top (
  input  logic                  clk,
  input  logic                  rst,
  input  operand_pkg::operand_t operand,
  input  logic                  operand_valid,
  output rns_pkg::residue_t     residue_a,
  output rns_pkg::residue_t     residue_b,
  output logic                  residue_valid,
  output rns_pkg::result_t      result,
  output logic                  result_valid
);

  residue_reducer #(
    .modulus (rns_pkg::mod_a)
  ) i_reduce_a (
    .clk           (clk),
    .rst           (rst),
    .operand       (operand),
    .operand_valid (operand_valid),
    .residue       (residue_a),
    .residue_valid (residue_valid)
  );

  // Same latency as channel a, so its strobe is not needed.
  residue_reducer #(
    .modulus (rns_pkg::mod_b)
  ) i_reduce_b (
    .clk           (clk),
    .rst           (rst),
    .operand       (operand),
    .operand_valid (operand_valid),
    .residue       (residue_b),
    .residue_valid ()
  );

  crt_combiner i_crt (
    .clk           (clk),
    .rst           (rst),
    .residue_a     (residue_a),
    .residue_b     (residue_b),
    .residue_valid (residue_valid),
    .result        (result),
    .result_valid  (result_valid)
  );

endmodule

// ==== design/operand_pkg.sv ====
package operand_pkg;

  // Input operand format.
  localparam int operand_width = 200;

  // Lookup chunking, 33 full chunks and a 2-bit top chunk.
  localparam int chunk_width = 6;
  localparam int chunk_count = 34;

  typedef logic [operand_width-1:0] operand_t;
  typedef logic [chunk_width-1:0]   chunk_t;   // Index into one chunk table.

endpackage

// ==== design/residue_reducer.sv ====
`timescale 1ns/10ps

module residue_reducer #(
  parameter int modulus = rns_pkg::mod_a
) (
  input  logic                  clk,
  input  logic                  rst,
  input  operand_pkg::operand_t operand,
  input  logic                  operand_valid,
  output rns_pkg::residue_t     residue,
  output logic                  residue_valid
);

  typedef rns_pkg::residue_t lut_t [2 ** operand_pkg::chunk_width];

  // Chunk value times its weight, reduced.
  function automatic lut_t build_lut(input int k);
    lut_t lut;
    int   w;
    w = rns_pkg::chunk_weight(k, modulus);
    for (int v = 0; v < 2 ** operand_pkg::chunk_width; v++)
    begin
      lut[v] = rns_pkg::residue_t'((v * w) % modulus);
    end
    return lut;
  endfunction

  rns_pkg::residue_t   chunk_res_q [operand_pkg::chunk_count];
  rns_pkg::chunk_sum_t sum_d;
  rns_pkg::chunk_sum_t sum_q;
  rns_pkg::chunk_sum_t folded;
  logic                vld_s1;
  logic                vld_s2;

  // Stage 1: one table per chunk.
  for (genvar k = 0; k < operand_pkg::chunk_count; k++)
  begin : g_chunk
    localparam lut_t lut = build_lut(k);
    operand_pkg::chunk_t chunk;

    if (k < operand_pkg::chunk_count - 1)
    begin : g_full
      assign chunk = operand[k*operand_pkg::chunk_width +: operand_pkg::chunk_width];
    end
    else
    begin : g_last
      // Short top chunk, zero extended.
      assign chunk = operand_pkg::chunk_t'(
        operand[operand_pkg::operand_width-1:k*operand_pkg::chunk_width]);
    end

    always_ff @(posedge clk)
    begin
      chunk_res_q[k] <= lut[chunk];
    end
  end

  // Stage 2: sum of all chunk residues.
  always_comb
  begin
    sum_d = '0;
    for (int k = 0; k < operand_pkg::chunk_count; k++)
    begin
      sum_d = sum_d + rns_pkg::chunk_sum_t'(chunk_res_q[k]);
    end
  end

  always_ff @(posedge clk)
  begin
    sum_q <= sum_d;
  end

  // Stage 3: fold the top bits back in, then one conditional subtract.
  assign folded = (sum_q >> rns_pkg::fold_bits)
                * rns_pkg::chunk_sum_t'(rns_pkg::fold_weight(modulus))
                + rns_pkg::chunk_sum_t'(sum_q[rns_pkg::fold_bits-1:0]);

  always_ff @(posedge clk)
  begin
    if (folded >= rns_pkg::chunk_sum_t'(modulus))
      residue <= rns_pkg::residue_t'(folded - rns_pkg::chunk_sum_t'(modulus));
    else
      residue <= rns_pkg::residue_t'(folded);
  end

  // Strobe follows the data through the three stages.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      vld_s1        <= 1'b0;
      vld_s2        <= 1'b0;
      residue_valid <= 1'b0;
    end
    else
    begin
      vld_s1        <= operand_valid;
      vld_s2        <= vld_s1;
      residue_valid <= vld_s2;
    end
  end

endmodule

// ==== design/rns_pkg.sv ====
package rns_pkg;

  // Channel moduli and their product.
  localparam int mod_a  = 997;
  localparam int mod_b  = 1009;
  localparam int mod_ab = mod_a * mod_b;   // 1,005,973.

  localparam int inv_a_mod_b = 84;   // 997 * 84 = 1 mod 1009.

  localparam int residue_width  = 11;
  localparam int result_width   = 20;
  localparam int sum_width      = 16;
  localparam int fold_bits      = 10;   // Low bits kept when folding.
  localparam int crt_prod_width = 17;

  typedef logic [residue_width-1:0]  residue_t;
  typedef logic [residue_width:0]    residue_wide_t;   // Headroom for a sign or a fold.
  typedef logic [result_width-1:0]   result_t;
  typedef logic [sum_width-1:0]      chunk_sum_t;      // Sum of 34 residues.
  typedef logic [crt_prod_width-1:0] crt_prod_t;

  // 2^(chunk_width * k) mod modulus.
  function automatic int chunk_weight(input int k, input int modulus);
    int w;
    w = 1 % modulus;
    for (int i = 0; i < k; i++)
    begin
      w = (w * (2 ** operand_pkg::chunk_width)) % modulus;
    end
    return w;
  endfunction

  // Weight of the bits above the fold point.
  function automatic int fold_weight(input int modulus);
    return (2 ** fold_bits) % modulus;
  endfunction

endpackage

// ==== sim.f ====
+incdir+include
design/operand_pkg.sv
design/rns_pkg.sv
design/residue_reducer.sv
design/crt_combiner.sv
design/mod_reduce_top.sv
sim/tb_mod_reduce.sv

// ==== include/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int directed_count = 8;

// Edge cases around both moduli and their product.
localparam logic [199:0] directed_operands [directed_count] = '{
  200'd0,
  200'd1,
  200'd997,       // Zero in channel a.
  200'd1009,      // Zero in channel b.
  200'd1005972,   // Largest result.
  200'd1005973,   // Wraps to zero.
  200'd1 << 199,  // Only the top chunk set.
  {200{1'b1}}
};

`endif

// ==== sim/tb_mod_reduce.sv ====
`timescale 1ns/10ps

module tb_mod_reduce;

  `include "tb_vectors.svh"

  localparam logic [199:0] wide_mod_a  = rns_pkg::mod_a;
  localparam logic [199:0] wide_mod_b  = rns_pkg::mod_b;
  localparam logic [199:0] wide_mod_ab = rns_pkg::mod_ab;

  localparam int residue_latency = 3;
  localparam int result_latency  = 5;
  localparam int drain_timeout   = 20;
  localparam int random_count    = 64;

  logic               clk;
  logic               rst;
  logic [199:0]       operand;
  logic               operand_valid;
  rns_pkg::residue_t  residue_a;
  rns_pkg::residue_t  residue_b;
  logic               residue_valid;
  rns_pkg::result_t   result;
  logic               result_valid;

  // Stimulus table with its expected values.
  logic [199:0] tab_operand [$];
  bit           tab_valid   [$];
  logic [199:0] tab_exp_a   [$];
  logic [199:0] tab_exp_b   [$];
  logic [199:0] tab_exp_ab  [$];

  // Operands in flight in arrival order.
  logic [199:0] fly_a         [$];
  logic [199:0] fly_b         [$];
  logic [199:0] fly_ab        [$];
  int unsigned  fly_res_stamp [$];
  int unsigned  fly_ab_stamp  [$];

  int unsigned cycle_count = 0;   // Counts falling edges.
  logic [31:0] lfsr_state;

  mod_reduce_top i_dut (
    .clk           (clk),
    .rst           (rst),
    .operand       (operand),
    .operand_valid (operand_valid),
    .residue_a     (residue_a),
    .residue_b     (residue_b),
    .residue_valid (residue_valid),
    .result        (result),
    .result_valid  (result_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [199:0] expected,
                             input logic [199:0] actual);
    if (expected !== actual)
    begin
      $display("ERR time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  // Taps at 32, 22, 2 and 1.
  function automatic logic next_lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [199:0] random_operand();
    logic [199:0] v;
    v = '0;
    for (int n = 0; n < 200; n++)
    begin
      v[n] = next_lfsr_bit();
    end
    return v;
  endfunction

  task automatic add_entry(input logic [199:0] op, input bit valid);
    tab_operand.push_back(op);
    tab_valid.push_back(valid);
    tab_exp_a.push_back(op % wide_mod_a);
    tab_exp_b.push_back(op % wide_mod_b);
    tab_exp_ab.push_back(op % wide_mod_ab);
  endtask

  task automatic build_table();
    // Directed operands back to back.
    for (int i = 0; i < directed_count; i++)
    begin
      add_entry(directed_operands[i], 1'b1);
    end
    repeat (3) add_entry('0, 1'b0);
    // Same operands again with a gap after each.
    for (int i = 0; i < directed_count; i++)
    begin
      add_entry(directed_operands[i], 1'b1);
      add_entry({200{1'b1}}, 1'b0);   // Data without strobe must be ignored.
    end
    for (int n = 0; n < random_count; n++)
    begin
      add_entry(random_operand(), 1'b1);
      if (n % 5 == 2)
        add_entry('0, 1'b0);
      if (n % 16 == 15)
        repeat (2) add_entry('0, 1'b0);
    end
  endtask

  // Outputs are sampled on the falling edge.
  always @(negedge clk)
  begin : monitor
    logic [199:0] exp_a;
    logic [199:0] exp_b;
    logic [199:0] exp_ab;
    int unsigned  stamp;
    cycle_count = cycle_count + 1;
    if (residue_valid === 1'b1)
    begin
      if (fly_a.size() == 0)
        abort_run("residue_valid pulsed while no operand was in flight");
      else
      begin
        exp_a = fly_a.pop_front();
        exp_b = fly_b.pop_front();
        stamp = fly_res_stamp.pop_front();
        check_value("residue_valid latency", stamp + residue_latency, cycle_count);
        check_value("residue_a", exp_a, residue_a);
        check_value("residue_b", exp_b, residue_b);
      end
    end
    if (result_valid === 1'b1)
    begin
      if (fly_ab.size() == 0)
        abort_run("result_valid pulsed while no operand was in flight");
      else
      begin
        exp_ab = fly_ab.pop_front();
        stamp  = fly_ab_stamp.pop_front();
        check_value("result_valid latency", stamp + result_latency, cycle_count);
        check_value("result", exp_ab, result);
      end
    end
  end

  initial
  begin : stimulus
    int wait_cycles;
    rst           = 1'b1;
    operand       = '0;
    operand_valid = 1'b0;
    lfsr_state    = 32'hfb48;
    build_table();

    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // No strobes while idle after reset.
    repeat (4)
    begin
      @(negedge clk);
      check_value("residue_valid", 1'b0, residue_valid);
      check_value("result_valid", 1'b0, result_valid);
    end

    for (int i = 0; i < tab_operand.size(); i++)
    begin
      @(posedge clk);
      operand       <= tab_operand[i];
      operand_valid <= tab_valid[i];
      if (tab_valid[i])
      begin
        fly_a.push_back(tab_exp_a[i]);
        fly_b.push_back(tab_exp_b[i]);
        fly_ab.push_back(tab_exp_ab[i]);
        fly_res_stamp.push_back(cycle_count + 1);   // Seen at the next falling edge.
        fly_ab_stamp.push_back(cycle_count + 1);
      end
    end
    @(posedge clk);
    operand       <= '0;
    operand_valid <= 1'b0;

    wait_cycles = 0;
    while (fly_a.size() != 0 && wait_cycles < drain_timeout)
    begin
      @(posedge clk);
      wait_cycles++;
    end
    if (fly_a.size() != 0)
      abort_run("Timeout, residue_valid never came for the last operands");

    wait_cycles = 0;
    while (fly_ab.size() != 0 && wait_cycles < drain_timeout)
    begin
      @(posedge clk);
      wait_cycles++;
    end
    if (fly_ab.size() != 0)
      abort_run("Timeout, result_valid never came for the last operands");

    // A few quiet cycles to catch late strobes.
    repeat (8) @(posedge clk);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
